// File: decodeExecute.f
+incdir+logic
logic/cpuPkg.sv
logic/registerFile.sv
logic/instrDecode.sv
logic/pipeDecodeExecute.sv
logic/executeUnit.sv
logic/decodeExecuteTop.sv
verification/tbClock.sv
verification/decodeExecuteTb.sv

// File: logic/cpuPkg.sv
// The instruction layout is fixed at 16 bits and opcodes 8 to 15 are reserved and treated as NOP.
`include "cpu_macros.svh"

package cpuPkg;

    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ALU  = 4'd1,    // R-format with the operation in func.
        ADDI = 4'd2,
        ANDI = 4'd3,
        LD   = 4'd4,
        ST   = 4'd5,
        BEQZ = 4'd6,
        HALT = 4'd7
    } opcode_e;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        AND = 3'd1,
        OR  = 3'd2,
        XOR = 3'd3,
        SHL = 3'd4,
        SHR = 3'd5
    } aluOp_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`REG_IDX_WIDTH-1:0] rd;
        logic [`REG_IDX_WIDTH-1:0] rs;
        logic [`REG_IDX_WIDTH-1:0] rt;
        logic [2:0]                func;
    } rFormat_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`REG_IDX_WIDTH-1:0] rd;
        logic [`REG_IDX_WIDTH-1:0] rs;
        logic [5:0]                imm;    // signed except for ANDI.
    } iFormat_t;

    // same word, two views.
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
    } instrWord_u;

endpackage

// File: logic/cpu_macros.svh
// Sizes assume a 16-bit datapath with eight registers, so the index width must stay log2 of the count.
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define DATA_WIDTH 16      // operand and result width.
`define REG_COUNT 8        // general purpose registers.
`define REG_IDX_WIDTH 3    // bits to select one register.

`endif

// File: logic/decodeExecuteTop.sv
// Results follow the capture edge with no forwarding or hazard check, so stall comes from outside.
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeExecuteTop import cpuPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic [15:0]               instr,
    input  logic                      wbEnable,
    input  logic [`REG_IDX_WIDTH-1:0] wbReg,
    input  logic [`DATA_WIDTH-1:0]    wbData,
    output logic [`DATA_WIDTH-1:0]    result,
    output logic [`DATA_WIDTH-1:0]    storeData,
    output logic                      branchTaken,
    output logic                      memRead,
    output logic                      memWrite,
    output logic                      memToReg,
    output logic                      regWrite,
    output logic [`REG_IDX_WIDTH-1:0] destReg,
    output logic                      halt
);

    // decode side.
    logic [`DATA_WIDTH-1:0]    decOpA, decOpB, decImmediate;
    aluOp_e                    decAluOp;
    logic                      decInvB, decCin, decSetLess, decAluSrc, decBranch;
    logic                      decMemRead, decMemWrite, decMemToReg, decRegWrite, decHalt;
    logic [`REG_IDX_WIDTH-1:0] decDestReg;

    // execute side.
    logic [`DATA_WIDTH-1:0]    opAQ, opBQ, immediateQ;
    aluOp_e                    aluOpQ;
    logic                      invBQ, cinQ, setLessQ, aluSrcQ, branchQ;
    logic                      memReadQ, memWriteQ, memToRegQ, regWriteQ, haltQ;
    logic [`REG_IDX_WIDTH-1:0] destRegQ;

    instrDecode u_instrDecode (
        .clk (clk), .reset (reset), .instr (instr),
        .wbEnable (wbEnable), .wbReg (wbReg), .wbData (wbData),
        .opA (decOpA), .opB (decOpB), .immediate (decImmediate),
        .aluOp (decAluOp), .invB (decInvB), .cin (decCin),
        .setLess (decSetLess), .aluSrc (decAluSrc), .branch (decBranch),
        .memRead (decMemRead), .memWrite (decMemWrite), .memToReg (decMemToReg),
        .regWrite (decRegWrite), .destReg (decDestReg), .halt (decHalt)
    );

    pipeDecodeExecute u_pipeDecodeExecute (
        .clk (clk), .reset (reset), .stall (stall),
        .opA (decOpA), .opB (decOpB), .immediate (decImmediate),
        .aluOp (decAluOp), .invB (decInvB), .cin (decCin),
        .setLess (decSetLess), .aluSrc (decAluSrc), .branch (decBranch),
        .memRead (decMemRead), .memWrite (decMemWrite), .memToReg (decMemToReg),
        .regWrite (decRegWrite), .destReg (decDestReg), .halt (decHalt),
        .opAQ (opAQ), .opBQ (opBQ), .immediateQ (immediateQ),
        .aluOpQ (aluOpQ), .invBQ (invBQ), .cinQ (cinQ),
        .setLessQ (setLessQ), .aluSrcQ (aluSrcQ), .branchQ (branchQ),
        .memReadQ (memReadQ), .memWriteQ (memWriteQ), .memToRegQ (memToRegQ),
        .regWriteQ (regWriteQ), .destRegQ (destRegQ), .haltQ (haltQ)
    );

    executeUnit u_executeUnit (
        .opAQ (opAQ), .opBQ (opBQ), .immediateQ (immediateQ),
        .aluOpQ (aluOpQ), .invBQ (invBQ), .cinQ (cinQ),
        .setLessQ (setLessQ), .aluSrcQ (aluSrcQ), .branchQ (branchQ),
        .memReadQ (memReadQ), .memWriteQ (memWriteQ), .memToRegQ (memToRegQ),
        .regWriteQ (regWriteQ), .destRegQ (destRegQ), .haltQ (haltQ),
        .result (result), .storeData (storeData), .branchTaken (branchTaken),
        .memRead (memRead), .memWrite (memWrite), .memToReg (memToReg),
        .regWrite (regWrite), .destReg (destReg), .halt (halt)
    );

endmodule

// File: logic/executeUnit.sv
// Branches report only taken or not taken, since targets and memory access live outside.
`timescale 1ns/1ps
`include "cpu_macros.svh"

module executeUnit import cpuPkg::*; (
    input  logic [`DATA_WIDTH-1:0]    opAQ,
    input  logic [`DATA_WIDTH-1:0]    opBQ,
    input  logic [`DATA_WIDTH-1:0]    immediateQ,
    input  aluOp_e                    aluOpQ,
    input  logic                      invBQ,
    input  logic                      cinQ,
    input  logic                      setLessQ,
    input  logic                      aluSrcQ,
    input  logic                      branchQ,
    input  logic                      memReadQ,
    input  logic                      memWriteQ,
    input  logic                      memToRegQ,
    input  logic                      regWriteQ,
    input  logic [`REG_IDX_WIDTH-1:0] destRegQ,
    input  logic                      haltQ,
    output logic [`DATA_WIDTH-1:0]    result,
    output logic [`DATA_WIDTH-1:0]    storeData,
    output logic                      branchTaken,
    output logic                      memRead,
    output logic                      memWrite,
    output logic                      memToReg,
    output logic                      regWrite,
    output logic [`REG_IDX_WIDTH-1:0] destReg,
    output logic                      halt
);

    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] sum;
    logic                   overflow;
    logic                   lessThan;

    assign operandB = (aluSrcQ ? immediateQ : opBQ) ^ {`DATA_WIDTH{invBQ}};
    assign sum      = opAQ + operandB + {{(`DATA_WIDTH-1){1'b0}}, cinQ};

    // signed overflow when both addends agree in sign and the sum does not.
    assign overflow = (opAQ[`DATA_WIDTH-1] == operandB[`DATA_WIDTH-1]) &&
                      (sum[`DATA_WIDTH-1] != opAQ[`DATA_WIDTH-1]);
    assign lessThan = sum[`DATA_WIDTH-1] ^ overflow;

    always_comb begin
        case (aluOpQ)
            ADD: begin
                if (setLessQ) begin
                    result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};
                end else begin
                    result = sum;
                end
            end
            AND: result = opAQ & operandB;
            OR:  result = opAQ | operandB;
            XOR: result = opAQ ^ operandB;
            SHL: result = opAQ << operandB[3:0];    // amount is low 4 bits.
            SHR: result = opAQ >> operandB[3:0];
            default: result = sum;
        endcase
    end

    assign branchTaken = branchQ && (opAQ == '0);    // branch on rs zero.
    assign storeData   = opBQ;

    assign memRead  = memReadQ;
    assign memWrite = memWriteQ;
    assign memToReg = memToRegQ;
    assign regWrite = regWriteQ;
    assign destReg  = destRegQ;
    assign halt     = haltQ;

endmodule

// File: logic/instrDecode.sv
// Combinational apart from the register file, and unused opcodes decode as NOP with controls low.
`timescale 1ns/1ps
`include "cpu_macros.svh"

module instrDecode import cpuPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  instrWord_u                instr,
    input  logic                      wbEnable,
    input  logic [`REG_IDX_WIDTH-1:0] wbReg,
    input  logic [`DATA_WIDTH-1:0]    wbData,
    output logic [`DATA_WIDTH-1:0]    opA,
    output logic [`DATA_WIDTH-1:0]    opB,
    output logic [`DATA_WIDTH-1:0]    immediate,
    output aluOp_e                    aluOp,
    output logic                      invB,
    output logic                      cin,
    output logic                      setLess,
    output logic                      aluSrc,
    output logic                      branch,
    output logic                      memRead,
    output logic                      memWrite,
    output logic                      memToReg,
    output logic                      regWrite,
    output logic [`REG_IDX_WIDTH-1:0] destReg,
    output logic                      halt
);

    logic [`REG_IDX_WIDTH-1:0] readIdxB;

    // port B reads rt for R-format, rd otherwise (store data).
    assign readIdxB = (instr.r.opcode == ALU) ? instr.r.rt : instr.i.rd;

    registerFile u_registerFile (
        .clk       (clk),
        .reset     (reset),
        .readIdxA  (instr.r.rs),
        .readIdxB  (readIdxB),
        .readDataA (opA),
        .readDataB (opB),
        .wbEnable  (wbEnable),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    assign immediate = (instr.i.opcode == ANDI) ?
                       {{(`DATA_WIDTH-6){1'b0}}, instr.i.imm} :
                       {{(`DATA_WIDTH-6){instr.i.imm[5]}}, instr.i.imm};
    assign destReg   = instr.r.rd;

    always_comb begin
        aluOp    = ADD;
        invB     = 1'b0;
        cin      = 1'b0;
        setLess  = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        regWrite = 1'b0;
        halt     = 1'b0;
        case (instr.r.opcode)
            ALU: begin
                regWrite = 1'b1;
                case (instr.r.func)
                    3'd1: begin    // sub.
                        invB = 1'b1;
                        cin  = 1'b1;
                    end
                    3'd2: aluOp = AND;
                    3'd3: aluOp = OR;
                    3'd4: aluOp = XOR;
                    3'd5: begin    // signed set-less-than from A minus B.
                        invB    = 1'b1;
                        cin     = 1'b1;
                        setLess = 1'b1;
                    end
                    3'd6: aluOp = SHL;
                    3'd7: aluOp = SHR;
                    default: aluOp = ADD;
                endcase
            end
            ADDI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            ANDI: begin
                aluOp    = AND;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            LD: begin
                aluSrc   = 1'b1;    // address is rs plus imm.
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            ST: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            BEQZ: begin
                aluSrc = 1'b1;
                branch = 1'b1;
            end
            HALT: halt = 1'b1;
            default: ;             // NOP and reserved opcodes.
        endcase
    end

endmodule

// File: logic/pipeDecodeExecute.sv
// Stall is a plain level with no handshake, and reset leaves an all-zero NOP bubble.
`timescale 1ns/1ps
`include "cpu_macros.svh"

module pipeDecodeExecute import cpuPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic [`DATA_WIDTH-1:0]    opA,
    input  logic [`DATA_WIDTH-1:0]    opB,
    input  logic [`DATA_WIDTH-1:0]    immediate,
    input  aluOp_e                    aluOp,
    input  logic                      invB,
    input  logic                      cin,
    input  logic                      setLess,
    input  logic                      aluSrc,
    input  logic                      branch,
    input  logic                      memRead,
    input  logic                      memWrite,
    input  logic                      memToReg,
    input  logic                      regWrite,
    input  logic [`REG_IDX_WIDTH-1:0] destReg,
    input  logic                      halt,
    output logic [`DATA_WIDTH-1:0]    opAQ,
    output logic [`DATA_WIDTH-1:0]    opBQ,
    output logic [`DATA_WIDTH-1:0]    immediateQ,
    output aluOp_e                    aluOpQ,
    output logic                      invBQ,
    output logic                      cinQ,
    output logic                      setLessQ,
    output logic                      aluSrcQ,
    output logic                      branchQ,
    output logic                      memReadQ,
    output logic                      memWriteQ,
    output logic                      memToRegQ,
    output logic                      regWriteQ,
    output logic [`REG_IDX_WIDTH-1:0] destRegQ,
    output logic                      haltQ
);

    always_ff @(posedge clk) begin
        if (reset) begin
            opAQ       <= '0;    // bubble.
            opBQ       <= '0;
            immediateQ <= '0;
            aluOpQ     <= ADD;
            invBQ      <= 1'b0;
            cinQ       <= 1'b0;
            setLessQ   <= 1'b0;
            aluSrcQ    <= 1'b0;
            branchQ    <= 1'b0;
            memReadQ   <= 1'b0;
            memWriteQ  <= 1'b0;
            memToRegQ  <= 1'b0;
            regWriteQ  <= 1'b0;
            destRegQ   <= '0;
            haltQ      <= 1'b0;
        end else if (!stall) begin
            // hold everything while stalled.
            opAQ       <= opA;
            opBQ       <= opB;
            immediateQ <= immediate;
            aluOpQ     <= aluOp;
            invBQ      <= invB;
            cinQ       <= cin;
            setLessQ   <= setLess;
            aluSrcQ    <= aluSrc;
            branchQ    <= branch;
            memReadQ   <= memRead;
            memWriteQ  <= memWrite;
            memToRegQ  <= memToReg;
            regWriteQ  <= regWrite;
            destRegQ   <= destReg;
            haltQ      <= halt;
        end
    end

endmodule

// File: logic/registerFile.sv
// Reads are combinational and return the write data when the same register is written that cycle.
`timescale 1ns/1ps
`include "cpu_macros.svh"

module registerFile (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`REG_IDX_WIDTH-1:0] readIdxA,
    input  logic [`REG_IDX_WIDTH-1:0] readIdxB,
    output logic [`DATA_WIDTH-1:0]    readDataA,
    output logic [`DATA_WIDTH-1:0]    readDataB,
    input  logic                      wbEnable,
    input  logic [`REG_IDX_WIDTH-1:0] wbReg,
    input  logic [`DATA_WIDTH-1:0]    wbData
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEnable) begin
            regs[wbReg] <= wbData;
        end
    end

    // write-through so a value written now is seen by decode now.
    assign readDataA = (wbEnable && (wbReg == readIdxA)) ? wbData : regs[readIdxA];
    assign readDataB = (wbEnable && (wbReg == readIdxB)) ? wbData : regs[readIdxB];

endmodule

// File: verification/decodeExecuteTb.sv
// Trace lines carry one cycle each, and expected columns describe the instruction of the line before.
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeExecuteTb;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_LINES    = 256;
    localparam int COLUMNS      = 14;

    logic                      clk;
    logic                      reset;
    logic                      stall;
    logic [15:0]               instr;
    logic                      wbEnable;
    logic [`REG_IDX_WIDTH-1:0] wbReg;
    logic [`DATA_WIDTH-1:0]    wbData;
    logic [`DATA_WIDTH-1:0]    result;
    logic [`DATA_WIDTH-1:0]    storeData;
    logic                      branchTaken, memRead, memWrite, memToReg, regWrite, halt;
    logic [`REG_IDX_WIDTH-1:0] destReg;

    logic [15:0] vectors [MAX_LINES][COLUMNS];    // one row per trace line.
    int lineCount  = 0;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    tbClock #(.PERIOD_NS(40)) u_tbClock (.clk(clk));

    decodeExecuteTop u_decodeExecuteTop (
        .clk (clk), .reset (reset), .stall (stall), .instr (instr),
        .wbEnable (wbEnable), .wbReg (wbReg), .wbData (wbData),
        .result (result), .storeData (storeData), .branchTaken (branchTaken),
        .memRead (memRead), .memWrite (memWrite), .memToReg (memToReg),
        .regWrite (regWrite), .destReg (destReg), .halt (halt)
    );

    task automatic loadTrace();
        int    fd;
        int    count;
        int    fileLine;
        string text;
        fd       = $fopen("verification/decodeExecute_trace.txt", "r");
        fileLine = 0;
        if (fd == 0) begin
            $display("could not open the trace file verification/decodeExecute_trace.txt");
            errorCount++;
            return;
        end
        while (!$feof(fd) && lineCount < MAX_LINES) begin
            text = "";
            void'($fgets(text, fd));
            fileLine++;
            if (text.len() < 2 || text.getc(0) == "#") continue;    // blank or comment.
            count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                vectors[lineCount][0], vectors[lineCount][1], vectors[lineCount][2],
                vectors[lineCount][3], vectors[lineCount][4], vectors[lineCount][5],
                vectors[lineCount][6], vectors[lineCount][7], vectors[lineCount][8],
                vectors[lineCount][9], vectors[lineCount][10], vectors[lineCount][11],
                vectors[lineCount][12], vectors[lineCount][13]);
            if (count != COLUMNS) begin
                $display("trace file line %0d is short, only %0d of %0d columns read",
                         fileLine, count, COLUMNS);
                errorCount++;
            end else begin
                lineCount++;
            end
        end
        $fclose(fd);
    endtask

    task automatic checkField(input string name, input int row,
                              input logic [15:0] expected, input logic [15:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("ERROR %s expected 0x%h got 0x%h at trace row %0d",
                     name, expected, actual, row);
            errorCount++;
        end
    endtask

    // hard stop in case the stimulus loop never ends.
    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("timeout, run did not finish within %0d cycles", cycleLimit);
            $display("checks %0d, errors %0d", checkCount, errorCount + 1);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        reset    = 1'b1;
        stall    = 1'b0;
        instr    = '0;
        wbEnable = 1'b0;
        wbReg    = '0;
        wbData   = '0;
        loadTrace();
        cycleLimit = lineCount + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        for (int row = 0; row < lineCount; row++) begin
            #2;
            reset    = 1'b0;
            stall    = vectors[row][0][0];
            instr    = vectors[row][1];
            wbEnable = vectors[row][2][0];
            wbReg    = vectors[row][3][`REG_IDX_WIDTH-1:0];
            wbData   = vectors[row][4];
            #36;    // 2 ns before the next edge.
            checkField("result", row, vectors[row][5], result);
            checkField("storeData", row, vectors[row][6], storeData);
            checkField("branchTaken", row, vectors[row][7], branchTaken);
            checkField("regWrite", row, vectors[row][8], regWrite);
            checkField("destReg", row, vectors[row][9], destReg);
            checkField("memRead", row, vectors[row][10], memRead);
            checkField("memWrite", row, vectors[row][11], memWrite);
            checkField("memToReg", row, vectors[row][12], memToReg);
            checkField("halt", row, vectors[row][13], halt);
            @(posedge clk);
        end
        if (lineCount == 0) begin
            $display("the trace holds no test vectors");
            errorCount++;
        end
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verification/decodeExecute_trace.txt
# stall instr wbEnable wbReg wbData | expected for previous line: result storeData branchTaken
# regWrite destReg memRead memWrite memToReg halt (all hex)
0 0000 1 1 1234 0000 0000 0 0 0 0 0 0 0
0 0000 1 2 00f0 0000 0000 0 0 0 0 0 0 0
0 0000 1 3 fffe 0000 0000 0 0 0 0 0 0 0
0 0000 1 4 0005 0000 0000 0 0 0 0 0 0 0
0 0000 1 5 8000 0000 0000 0 0 0 0 0 0 0
0 1e50 1 6 0003 0000 0000 0 0 0 0 0 0 0
0 1e51 0 0 0000 1324 00f0 0 1 7 0 0 0 0
0 1e52 0 0 0000 1144 00f0 0 1 7 0 0 0 0
0 1e53 0 0 0000 0030 00f0 0 1 7 0 0 0 0
0 1e54 0 0 0000 12f4 00f0 0 1 7 0 0 0 0
0 1ee5 0 0 0000 12c4 00f0 0 1 7 0 0 0 0
0 1f1d 0 0 0000 0001 0005 0 1 7 0 0 0 0
0 1f65 0 0 0000 0000 fffe 0 1 7 0 0 0 0
0 1e76 0 0 0000 0001 0005 0 1 7 0 0 0 0
0 1f77 0 0 0000 91a0 0003 0 1 7 0 0 0 0
0 1f90 1 6 0010 1000 0003 0 1 7 0 0 0 0
0 233d 0 0 0000 0100 00f0 0 1 7 0 0 0 0
0 34fc 0 0 0000 0002 1234 0 1 1 0 0 0 0
0 467f 0 0 0000 003c 00f0 0 1 2 0 0 0 0
0 5284 0 0 0000 1233 fffe 0 1 3 1 0 1 0
0 6002 0 0 0000 00f4 1234 0 0 1 0 1 0 0
0 6102 0 0 0000 0002 0000 1 0 0 0 0 0 0
0 7440 0 0 0000 0007 0000 0 0 0 0 0 0 0
0 b2c0 0 0 0000 1324 00f0 0 0 2 0 0 0 1
0 1664 0 0 0000 1232 1234 0 0 1 0 0 0 0
1 1851 0 0 0000 1231 0005 0 1 3 0 0 0 0
1 1851 0 0 0000 1231 0005 0 1 3 0 0 0 0
1 1851 0 0 0000 1231 0005 0 1 3 0 0 0 0
0 1851 0 0 0000 1231 0005 0 1 3 0 0 0 0
0 0000 0 0 0000 1144 00f0 0 1 4 0 0 0 0
0 0000 0 0 0000 0000 0000 0 0 0 0 0 0 0

// File: verification/tbClock.sv
// Free-running clock that starts low, so the first rising edge comes half a period after time zero.
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;    // 50 percent duty.

endmodule
